/* list.f */
+incdir+common
common/dotp_pkg.sv
hw/vec_ingress.sv
dot_pipe/dot_pipe.sv
hw/result_egress.sv
hw/dotp_top.sv
verif/tb_clkgen.sv
verif/dotp_tb.sv

/* Bender.yml */
package:
  name: dotp_engine

export_include_dirs:
  - common

sources:
  - files:
      - common/dotp_pkg.sv
      - hw/vec_ingress.sv
      - dot_pipe/dot_pipe.sv
      - hw/result_egress.sv
      - hw/dotp_top.sv

  - target: test
    files:
      - verif/tb_clkgen.sv
      - verif/dotp_tb.sv

/* verif/dotp_tb.sv */
// ==============================
// Dot-product engine testbench
// Table-driven producer, consumer and protocol monitor
// ==============================

`include "dotp_defs.svh"

module dotp_tb;

   timeunit 1ns;
   timeprecision 100ps;

   import dotp_pkg::*;

   localparam int NTEST       = 24;
   localparam int SEED        = 58712;
   localparam int MAX_DELAY   = 30;
   localparam int TIMEOUT_CYC = NTEST * (`DOTP_LATENCY + MAX_DELAY + 10);

   logic clk;
   logic rst;
   logic in_req;
   vec_t in_data;
   logic in_ack;
   logic out_req;
   res_t out_data;
   logic out_ack;

   // ==============================
   // Stimulus table
   // ==============================
   vec_t tbl_vec   [NTEST];
   int   tbl_gap   [NTEST];
   int   tbl_delay [NTEST];
   res_t tbl_exp   [NTEST];

   int err_cnt  = 0;
   int pass_cnt = 0;
   int fail_cnt = 0;
   int done_cnt = 0;
   int cycle_cnt;

   // Monitor state, values seen at the previous rising edge
   logic ack_q    = 1'b0;
   logic req_q    = 1'b0;
   logic oreq_q   = 1'b0;
   logic oack_q   = 1'b0;
   res_t odata_q  = '0;
   logic req_seen = 1'b0;
   int   acc_cnt  = 0;
   int   cons_cnt = 0;
   int   max_out  = 0;

   tb_clkgen clkgen_i (
      .clk (clk),
      .rst (rst)
   );

   dotp_top dotp_top_i (
      .clk      (clk),
      .rst      (rst),
      .in_req   (in_req),
      .in_data  (in_data),
      .in_ack   (in_ack),
      .out_req  (out_req),
      .out_data (out_data),
      .out_ack  (out_ack)
   );

   // Compare and report a wrong value
   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      if (exp !== act) begin
         err_cnt++;
         $display("ERR t=%0t %s expected %h actual %h", $time, name, exp, act);
      end
   endtask

   // Reference model, full-precision sum reduced modulo 2^16
   function automatic res_t dot_ref(input vec_t v);
      logic [63:0] acc;
      acc = '0;
      for (int p = 0; p < `DOTP_LEN / 2; p++) begin
         acc = acc + 64'(v[2*p]) * 64'(v[2*p+1]);
      end
      return res_t'(acc % (64'd1 << `DOTP_WIDTH));
   endfunction

   // Directed entries first, then random ones
   task automatic build_table();
      for (int i = 0; i < NTEST; i++) begin
         tbl_gap[i]   = 0;
         tbl_delay[i] = 0;
         tbl_vec[i]   = '0;
         if (i == 1) begin
            // Small integers 1..8, sum 100
            for (int j = 0; j < `DOTP_LEN; j++) tbl_vec[i][j] = elem_t'(j + 1);
         end else if (i == 2) begin
            // All ones, every product wraps to 1
            tbl_vec[i] = '1;
         end else if (i == 3) begin
            tbl_vec[i][0] = 16'h0100;
            tbl_vec[i][1] = 16'h0100;
            tbl_vec[i][2] = 16'h8000;
            tbl_vec[i][3] = 16'h0002;
            tbl_vec[i][4] = 16'h1234;
            tbl_vec[i][5] = 16'h5678;
            tbl_vec[i][6] = 16'h00ff;
            tbl_vec[i][7] = 16'h0101;
         end else if (i >= 4) begin
            for (int j = 0; j < `DOTP_LEN; j++) tbl_vec[i][j] = elem_t'($urandom);
            if (i >= 8 && i < 14) begin
               // Slow consumer, FIFO fills and credit runs out
               tbl_delay[i] = MAX_DELAY;
            end else if (i >= 14) begin
               tbl_gap[i]   = $urandom_range(0, 3);
               tbl_delay[i] = $urandom_range(0, 5);
            end
         end
         tbl_exp[i] = dot_ref(tbl_vec[i]);
      end
   endtask

   // ==============================
   // Producer and consumer
   // ==============================
   task automatic run_producer();
      for (int i = 0; i < NTEST; i++) begin
         repeat (tbl_gap[i]) @(negedge clk);
         in_data = tbl_vec[i];
         in_req  = 1'b1;
         @(negedge clk);
         while (!in_ack) @(negedge clk);
         in_req = 1'b0;
         while (in_ack) @(negedge clk);
      end
   endtask

   task automatic run_consumer();
      res_t got;
      int   errs_before;
      for (int i = 0; i < NTEST; i++) begin
         errs_before = err_cnt;
         while (!out_req) @(negedge clk);
         got = out_data;
         check_value("out_data", tbl_exp[i], got);
         repeat (tbl_delay[i]) @(negedge clk);
         out_ack = 1'b1;
         while (out_req) @(negedge clk);
         // Delayed entries keep out_ack up a while after the req fall
         repeat (tbl_delay[i] % 4) @(negedge clk);
         out_ack = 1'b0;
         if (err_cnt == errs_before) pass_cnt++;
         else fail_cnt++;
         $display("test %0d %s result %h expected %h", i,
                  (err_cnt == errs_before) ? "pass" : "fail", got, tbl_exp[i]);
         done_cnt = i + 1;
      end
   endtask

   // ==============================
   // Protocol monitor
   // ==============================
   // Samples before the edge updates, so DUT outputs and driven inputs are settled
   always @(posedge clk) begin
      if (rst || !req_seen) begin
         check_value("in_ack", 0, in_ack);
         check_value("out_req", 0, out_req);
      end
      if (!rst) begin
         if (in_req) req_seen = 1'b1;
         // Result leaves when out_req falls
         if (oreq_q && !out_req) cons_cnt++;
         if (in_ack && !ack_q) begin
            check_value("in_req", 1, req_q);
            check_value("unconsumed<depth", 1, (acc_cnt - cons_cnt) < `DOTP_FIFO_DEPTH);
            acc_cnt++;
            if (acc_cnt - cons_cnt > max_out) max_out = acc_cnt - cons_cnt;
         end
         if (out_req && !oreq_q) check_value("out_ack", 0, oack_q);
         if (out_req && oreq_q) check_value("out_data", odata_q, out_data);
      end
      ack_q   = in_ack;
      req_q   = in_req;
      oreq_q  = out_req;
      oack_q  = out_ack;
      odata_q = out_data;
   end

   // Run limit from the table length
   initial begin : watchdog
      cycle_cnt = 0;
      while (cycle_cnt < TIMEOUT_CYC) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("Timeout after %0d cycles, only %0d of %0d results came back",
               cycle_cnt, done_cnt, NTEST);
      $display("*** FAILED ***");
      $finish;
   end

   // ==============================
   // Main sequence
   // ==============================
   initial begin
      in_req  = 1'b0;
      in_data = '0;
      out_ack = 1'b0;
      void'($urandom(SEED));
      build_table();
      wait (!rst);
      @(negedge clk);
      fork
         run_producer();
         run_consumer();
      join
      repeat (4) @(negedge clk);
      // Back-pressure must have filled every slot, and nothing lost
      check_value("peak unconsumed", `DOTP_FIFO_DEPTH, max_out);
      check_value("accepted count", NTEST, acc_cnt);
      check_value("consumed count", NTEST, cons_cnt);
      $display("tests %0d passed %0d failed %0d errors %0d", NTEST, pass_cnt, fail_cnt,
               err_cnt);
      if (err_cnt == 0 && pass_cnt == NTEST) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

/* verif/tb_clkgen.sv */
// ==============================
// Testbench clock and reset
// 4 ns clock, reset held for 8 cycles
// ==============================

module tb_clkgen (
   output logic clk,
   output logic rst
);

   timeunit 1ns;
   timeprecision 100ps;

   // Free-running clock, 2 ns per half period
   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Reset released on a falling edge, away from the sampling edge
   initial begin
      rst = 1'b1;
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
   end

endmodule

/* hw/dotp_top.sv */
// ==============================
// Dot-product engine top
// Ingress, pipeline and egress
// ==============================

module dotp_top (
   input  logic           clk,
   input  logic           rst,
   input  logic           in_req,
   input  dotp_pkg::vec_t in_data,
   output logic           in_ack,
   output logic           out_req,
   output dotp_pkg::res_t out_data,
   input  logic           out_ack
);

   import dotp_pkg::*;

   // Issue path, ingress to pipeline
   logic issue_valid;
   vec_t issue_vec;

   // Result path, pipeline to egress
   logic res_valid;
   res_t res_data;

   // Credit return, egress to ingress
   logic pop;

   // ==============================
   // Input side
   // ==============================
   vec_ingress vec_ingress_i (
      .clk         (clk),
      .rst         (rst),
      .in_req      (in_req),
      .in_data     (in_data),
      .in_ack      (in_ack),
      .pop         (pop),
      .issue_valid (issue_valid),
      .issue_vec   (issue_vec)
   );

   // Fixed latency, never stalls
   dot_pipe dot_pipe_i (
      .clk         (clk),
      .rst         (rst),
      .issue_valid (issue_valid),
      .issue_vec   (issue_vec),
      .res_valid   (res_valid),
      .res_data    (res_data)
   );

   // ==============================
   // Output side
   // ==============================
   result_egress result_egress_i (
      .clk       (clk),
      .rst       (rst),
      .res_valid (res_valid),
      .res_data  (res_data),
      .out_req   (out_req),
      .out_data  (out_data),
      .out_ack   (out_ack),
      .pop       (pop)
   );

endmodule

/* hw/result_egress.sv */
// ==============================
// Result egress
// Result FIFO and four-phase sender
// ==============================

`include "dotp_defs.svh"

module result_egress (
   input  logic           clk,
   input  logic           rst,
   input  logic           res_valid,
   input  dotp_pkg::res_t res_data,
   output logic           out_req,
   output dotp_pkg::res_t out_data,
   input  logic           out_ack,
   output logic           pop
);

   import dotp_pkg::*;

   localparam int DEPTH = `DOTP_FIFO_DEPTH;
   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);

   // Storage, no reset needed on payload
   res_t             mem [DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;

   logic             wr_en;
   logic             rd_en;
   logic             empty;

   // Pipeline cannot wait, so every result is written
   assign wr_en = res_valid;

   // Transfer completes when the consumer acks the request
   assign rd_en = out_req && out_ack;

   assign empty = (count == '0);

   // ==============================
   // FIFO storage and pointers
   // ==============================
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= res_data;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         // Pointers wrap at the depth
         if (wr_en) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end

         // Occupancy, write and read may coincide
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Head of queue drives the output bus
   assign out_data = mem[rd_ptr];

   // ==============================
   // Four-phase sender
   // ==============================
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         out_req <= 1'b0;
         pop     <= 1'b0;
      end else begin
         // Pop pulse lines up with the req fall
         pop <= rd_en;
         if (rd_en) begin
            out_req <= 1'b0;
         end else if (!out_req && !out_ack && !empty) begin
            // Previous ack must be gone before a new request
            out_req <= 1'b1;
         end
      end
   end

   // Credit rule upstream keeps room for every result
   assert property (@(posedge clk) disable iff (rst)
      wr_en |-> (count < DEPTH));

   // Head held steady for the whole request
   assert property (@(posedge clk) disable iff (rst)
      (out_req && $past(out_req)) |-> (out_data == $past(out_data)));

endmodule

/* dot_pipe/dot_pipe.sv */
// ==============================
// Dot-product pipeline
// Four pair products into a two-level adder tree
// ==============================

`include "dotp_defs.svh"

module dot_pipe (
   input  logic           clk,
   input  logic           rst,
   input  logic           issue_valid,
   input  dotp_pkg::vec_t issue_vec,
   output logic           res_valid,
   output dotp_pkg::res_t res_data
);

   import dotp_pkg::*;

   localparam int LAT    = `DOTP_LATENCY;
   localparam int NPAIR  = `DOTP_LEN / 2;
   localparam int WARM_W = $clog2(LAT + 1);

   // Stage registers
   vec_t              in_r;
   elem_t             mult_r [NPAIR];
   elem_t             add_r  [NPAIR/2];
   res_t              sum_r;

   // Valid marker per stage
   logic [LAT-1:0]    valid_sr;

   // Cycles since reset, saturating at the latency
   logic [WARM_W-1:0] warm_cnt;

   // ==============================
   // Datapath
   // ==============================
   // Free running, no stall, no reset on payload
   always_ff @(posedge clk) begin
      // Stage 1 input register
      in_r <= issue_vec;

      // Stage 2 pair products, wrapped to element width
      for (int i = 0; i < NPAIR; i++) begin
         mult_r[i] <= elem_t'(in_r[2*i] * in_r[2*i+1]);
      end

      // Stage 3 first adder level
      for (int i = 0; i < NPAIR/2; i++) begin
         add_r[i] <= elem_t'(mult_r[2*i] + mult_r[2*i+1]);
      end

      // Stage 4 final adder
      sum_r <= res_t'(add_r[0] + add_r[1]);
   end

   assign res_data = sum_r;

   // ==============================
   // Valid delay line
   // ==============================
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         valid_sr <= '0;
      end else begin
         valid_sr <= {valid_sr[LAT-2:0], issue_valid};
      end
   end

   // Oldest stage marks the result
   assign res_valid = valid_sr[LAT-1];

   // Warm-up counter for the latency checks
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         warm_cnt <= '0;
      end else if (warm_cnt < LAT) begin
         warm_cnt <= warm_cnt + 1'b1;
      end
   end

   // Nothing can emerge before the pipe has filled
   assert property (@(posedge clk) disable iff (rst)
      (warm_cnt < LAT) |-> !res_valid);

   // Each issue comes out exactly LAT cycles later
   assert property (@(posedge clk) disable iff (rst)
      (warm_cnt == LAT) |-> (res_valid == $past(issue_valid, LAT)));

endmodule

/* hw/vec_ingress.sv */
// ==============================
// Vector ingress
// Four-phase receiver with credit-limited issue
// ==============================

`include "dotp_defs.svh"

module vec_ingress (
   input  logic           clk,
   input  logic           rst,
   input  logic           in_req,
   input  dotp_pkg::vec_t in_data,
   output logic           in_ack,
   input  logic           pop,
   output logic           issue_valid,
   output dotp_pkg::vec_t issue_vec
);

   import dotp_pkg::*;

   // Credit counter must hold 0 through the full depth
   localparam int CRED_W = $clog2(`DOTP_FIFO_DEPTH + 1);

   logic              accept;
   logic [CRED_W-1:0] credit;
   vec_t              vec_r;

   // New request, nothing pending, and room downstream
   assign accept = in_req && !in_ack && (credit < `DOTP_FIFO_DEPTH);

   // ==============================
   // Handshake and issue pulse
   // ==============================
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         in_ack      <= 1'b0;
         issue_valid <= 1'b0;
      end else begin
         // One-cycle issue with the ack edge
         issue_valid <= accept;
         if (accept) begin
            in_ack <= 1'b1;
         end else if (in_ack && !in_req) begin
            // Producer released, close the handshake
            in_ack <= 1'b0;
         end
      end
   end

   // Capture register, loaded only on acceptance
   always_ff @(posedge clk) begin
      if (accept) begin
         vec_r <= in_data;
      end
   end

   assign issue_vec = vec_r;

   // ==============================
   // Credit tracking
   // ==============================
   // Counts vectors in the pipeline or the FIFO
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         credit <= '0;
      end else begin
         case ({accept, pop})
            2'b10:   credit <= credit + 1'b1;
            2'b01:   credit <= credit - 1'b1;
            default: credit <= credit;
         endcase
      end
   end

   // Outstanding work never exceeds FIFO room
   assert property (@(posedge clk) disable iff (rst) credit <= `DOTP_FIFO_DEPTH);

   // Issue only starts a new handshake
   assert property (@(posedge clk) disable iff (rst) issue_valid |-> !$past(in_ack));

endmodule

/* common/dotp_pkg.sv */
// ==============================
// Dot-product engine types
// Element, vector and result
// ==============================

`include "dotp_defs.svh"

package dotp_pkg;

   // ==============================
   // Element
   // ==============================

   // One unsigned input element
   // All arithmetic wraps at this width
   typedef logic [`DOTP_WIDTH-1:0] elem_t;

   // ==============================
   // Vector
   // ==============================

   // Full input vector, element 0 in the low bits
   // Pairs are (0,1) (2,3) (4,5) (6,7)
   typedef elem_t [`DOTP_LEN-1:0] vec_t;

   // ==============================
   // Result
   // ==============================

   // Sum of the four pair products, modulo 2^width
   typedef logic [`DOTP_WIDTH-1:0] res_t;

endpackage

/* common/dotp_defs.svh */
// ==============================
// Dot-product engine constants
// Sizes and latency shared by RTL and testbench
// ==============================

`ifndef DOTP_DEFS_SVH
`define DOTP_DEFS_SVH

// ==============================
// Data sizes
// ==============================

// Width of one element and of one result
`define DOTP_WIDTH 16

// Elements per vector, taken as four pairs
`define DOTP_LEN 8

// ==============================
// Pipeline and queueing
// ==============================

// Cycles from issue to result
// Input reg, product, partial sum, final sum
`define DOTP_LATENCY 4

// Result slots in the output FIFO
// Also the credit limit on the input side
`define DOTP_FIFO_DEPTH 4

`endif
